// File: all.f
+incdir+.
ghtPkg.sv
ghtRam.sv
ghtBank.sv
ghtUpdateCtrl.sv
ghtLookup.sv
ght.sv
ghtTb.sv

// File: ght.sv
////////////////////
// global history table
// 64k one-bit predictions in 8 banks, one lookup port,
// two update ports with valid/ready
////////////////////

`timescale 1ns/1ps

module ght (
    input  logic             clk,
    input  logic             rst,
    input  logic             readClkEn,
    input  ghtPkg::ghtIndexT ipBits,
    input  ghtPkg::ghtIndexT history,
    output logic             pred,
    output logic             predValid,
    input  ghtPkg::ghtWriteT write0,
    input  ghtPkg::ghtWriteT write1,
    output logic             ready0,
    output logic             ready1
);
    import ghtPkg::*;

    bankWriteT [GhtBanks-1:0] bankCmd;
    logic [GhtBanks-1:0] bankBits;
    rowT readRow;
    colT readCol;

    ghtUpdateCtrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .write0  (write0),
        .write1  (write1),
        .ready0  (ready0),
        .ready1  (ready1),
        .bankCmd (bankCmd)
    );

    ghtLookup u_lookup (
        .clk       (clk),
        .rst       (rst),
        .readClkEn (readClkEn),
        .ipBits    (ipBits),
        .history   (history),
        .bankBits  (bankBits),
        .readRow   (readRow),
        .readCol   (readCol),
        .pred      (pred),
        .predValid (predValid)
    );

    for (genvar k = 0; k < GhtBanks; k++) begin : gBank
        ghtBank u_bank (
            .clk     (clk),
            .cmd     (bankCmd[k]),
            .readRow (readRow),
            .readCol (readCol),
            .predBit (bankBits[k])
        );
    end

endmodule

// File: ghtBank.sv
////////////////////
// ght bank
// decodes column writes and row clears into bit enables
// and picks the addressed column bit for lookup
////////////////////

`timescale 1ns/1ps

module ghtBank (
    input  logic              clk,
    input  ghtPkg::bankWriteT cmd,
    input  ghtPkg::rowT       readRow,
    input  ghtPkg::colT       readCol,
    output logic              predBit
);
    import ghtPkg::*;

    rowDataT readData;
    rowDataT writeData;
    rowDataT writeBitEn;
    logic wen;
    logic [15:0] group;

    // clear wins over a column write
    assign wen = cmd.en | cmd.clear;

    always_comb begin
        for (int i = 0; i < GhtCols; i++) begin
            writeBitEn[i] = cmd.clear | (cmd.col == colT'(i));
            writeData[i] = cmd.val & ~cmd.clear;
        end
    end

    ghtRam u_ram (
        .clk        (clk),
        .readRow    (readRow),
        .readData   (readData),
        .writeRow   (cmd.row),
        .writeData  (writeData),
        .writeBitEn (writeBitEn),
        .wen        (wen)
    );

    // column select in two steps, 16 groups of 16 bits
    always_comb begin
        group = readData[{readCol[7:4], 4'h0} +: 16];
        predBit = group[readCol[3:0]];
    end

endmodule

// File: ghtLookup.sv
////////////////////
// ght lookup
// registers ip xor history and picks the prediction bit
////////////////////

`timescale 1ns/1ps

module ghtLookup (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          readClkEn,
    input  ghtPkg::ghtIndexT              ipBits,
    input  ghtPkg::ghtIndexT              history,
    input  logic [ghtPkg::GhtBanks-1:0]   bankBits,
    output ghtPkg::rowT                   readRow,
    output ghtPkg::colT                   readCol,
    output logic                          pred,
    output logic                          predValid
);
    import ghtPkg::*;

    ghtIndexT indexReg;

    // index held while readClkEn is low
    always_ff @(posedge clk) begin
        if (rst) begin
            indexReg <= '0;
            predValid <= 1'b0;
        end else begin
            if (readClkEn) begin
                indexReg <= ipBits ^ history;
            end
            predValid <= readClkEn;
        end
    end

    // every bank reads the same row and column
    assign readRow = rowOf(indexReg);
    assign readCol = colOf(indexReg);

    assign pred = bankBits[bankOf(indexReg)];

endmodule

// File: ghtPkg.sv
////////////////////
// global history table package
// table geometry, index fields, update and bank command structs
////////////////////

package ghtPkg;

    localparam int GhtIndexBits = 16;
    localparam int GhtBanks = 8;
    localparam int GhtRows = 32;
    localparam int GhtCols = 256;
    localparam int InitCycles = 32;

    typedef logic [GhtIndexBits-1:0] ghtIndexT;
    typedef logic [2:0] bankIdT;
    typedef logic [4:0] rowT;
    typedef logic [7:0] colT;
    typedef logic [GhtCols-1:0] rowDataT;

    // one update port request
    typedef struct packed {
        logic valid;
        ghtIndexT addr;
        logic val;
    } ghtWriteT;

    // write command for a single bank
    typedef struct packed {
        logic en;
        logic clear;
        rowT row;
        colT col;
        logic val;
    } bankWriteT;

    typedef enum logic {
        CtrlInit,
        CtrlRun
    } ctrlStateT;

    // bank from index bits 7:6 and 0
    function automatic bankIdT bankOf(ghtIndexT idx);
        return {idx[7:6], idx[0]};
    endfunction

    function automatic rowT rowOf(ghtIndexT idx);
        return idx[5:1];
    endfunction

    function automatic colT colOf(ghtIndexT idx);
        return idx[15:8];
    endfunction

endpackage

// File: ghtRam.sv
////////////////////
// ght bank storage
// 32 rows of 256 bits, per-bit write enable, write-first async read
////////////////////

`timescale 1ns/1ps

module ghtRam (
    input  logic             clk,
    input  ghtPkg::rowT      readRow,
    output ghtPkg::rowDataT  readData,
    input  ghtPkg::rowT      writeRow,
    input  ghtPkg::rowDataT  writeData,
    input  ghtPkg::rowDataT  writeBitEn,
    input  logic             wen
);
    import ghtPkg::*;

    rowDataT mem [GhtRows];

    // read straight from the array so a write shows up right after the edge
    assign readData = mem[readRow];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[writeRow] <= (mem[writeRow] & ~writeBitEn) | (writeData & writeBitEn);
        end
    end

    writeRowKnown: assert property (
        @(posedge clk) wen |-> !$isunknown(writeRow)
    ) else $error("ghtRam write with unknown row");

endmodule

// File: ghtTbModel.svh
////////////////////
// ght reference model
// full table, save buffer and ready rule, stepped once per clock edge
////////////////////

`ifndef GHT_TB_MODEL_SVH
`define GHT_TB_MODEL_SVH

logic modelTable [1 << GhtIndexBits];
logic modelInit = 1'b1;
logic [4:0] modelRow = '0;
logic modelSavedValid = 1'b0;
ghtIndexT modelSavedAddr;
logic modelSavedVal;
ghtIndexT modelIndex = '0;
logic modelPredValid = 1'b0;
logic modelAcc0;
logic modelAcc1;

// bank is index bits 7:6 and 0
function automatic logic sameBank(input ghtIndexT a, input ghtIndexT b);
    return (a[7:6] == b[7:6]) && (a[0] == b[0]);
endfunction

function automatic logic modelReady();
    return !modelInit && !modelSavedValid;
endfunction

// one row across all columns of all banks
task automatic clearRow(input logic [4:0] row);
    for (int c = 0; c < GhtCols; c++) begin
        for (int b = 0; b < GhtBanks; b++) begin
            modelTable[{c[7:0], b[2:1], row, b[0]}] = 1'b0;
        end
    end
endtask

task automatic modelStep();
    logic coll;
    modelAcc0 = 1'b0;
    modelAcc1 = 1'b0;
    if (rst) begin
        modelInit = 1'b1;
        modelRow = '0;
        modelSavedValid = 1'b0;
        modelIndex = '0;
        modelPredValid = 1'b0;
    end else begin
        modelAcc0 = modelReady() && write0.valid;
        modelAcc1 = modelReady() && write1.valid;
        coll = modelAcc0 && modelAcc1 && sameBank(write0.addr, write1.addr);
        if (modelInit) begin
            clearRow(modelRow);
            modelInit = (modelRow != 5'(InitCycles - 1));
            modelRow++;
        end
        if (modelSavedValid) modelTable[modelSavedAddr] = modelSavedVal;
        if (modelAcc0) modelTable[write0.addr] = write0.val;
        if (modelAcc1 && !coll) modelTable[write1.addr] = write1.val;
        modelSavedValid = coll;
        modelSavedAddr = write1.addr;
        modelSavedVal = write1.val;
        if (readClkEn) modelIndex = ipBits ^ history;
        modelPredValid = readClkEn;
    end
endtask

`endif

// File: ghtTb.sv
////////////////////
// ght testbench
// directed and random updates and lookups against a model
////////////////////

`timescale 1ns/1ps

module ghtTb;
    import ghtPkg::*;

    localparam int ResetPhase = 2 + InitCycles + 8;
    localparam int DirectedPhase = 64 + 60;
    localparam int RandomCycles = 2000;
    localparam int ReadbackPhase = 40;
    localparam int TimeoutCycles =
        2 * (2 * ResetPhase + DirectedPhase + RandomCycles + ReadbackPhase);
    // two banks and 16 indices, so collisions are frequent
    localparam ghtIndexT SmallMask = 16'h0303;

    logic clk = 1'b0;
    logic rst;
    logic readClkEn;
    ghtIndexT ipBits;
    ghtIndexT history;
    logic pred;
    logic predValid;
    ghtWriteT write0;
    ghtWriteT write1;
    logic ready0;
    logic ready1;
    logic [31:0] rngState = 32'd20;
    int cycleCount = 0;

    `include "ghtTbModel.svh"

    ght u_dut (
        .clk       (clk),
        .rst       (rst),
        .readClkEn (readClkEn),
        .ipBits    (ipBits),
        .history   (history),
        .pred      (pred),
        .predValid (predValid),
        .write0    (write0),
        .write1    (write1),
        .ready0    (ready0),
        .ready1    (ready1)
    );

    always #20 clk = ~clk;

    task automatic reportFailure(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TimeoutCycles) begin
            reportFailure($sformatf("run went past the limit of %0d cycles", TimeoutCycles));
        end
    end

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rngState = x;
        return x;
    endfunction

    function automatic ghtWriteT mkWrite(input logic v, input ghtIndexT a, input logic d);
        ghtWriteT w;
        w.valid = v;
        w.addr = a;
        w.val = d;
        return w;
    endfunction

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            reportFailure($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                $time, name, got, exp));
        end
    endtask

    task automatic checkReady(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            reportFailure($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                $time, name, got, exp));
        end
    endtask

    // one clock, model update, compare, then inputs may change at +2 ns
    task automatic step();
        @(posedge clk);
        modelStep();
        #1;
        checkReady("ready0", ready0, modelReady());
        checkReady("ready1", ready1, modelReady());
        checkBit("predValid", predValid, modelPredValid);
        if (!modelInit) checkBit("pred", pred, modelTable[modelIndex]);
        #1;
    endtask

    task automatic issueWrites(input ghtWriteT w0, input ghtWriteT w1);
        int waited;
        waited = 0;
        write0 = w0;
        write1 = w1;
        while (write0.valid || write1.valid) begin
            step();
            if (modelAcc0) write0.valid = 1'b0;
            if (modelAcc1) write1.valid = 1'b0;
            waited++;
            if (waited > 40) reportFailure("update ports never became ready");
        end
    endtask

    task automatic lookupIndex(input ghtIndexT idx, input logic exp);
        history = ghtIndexT'(nextRand());
        ipBits = idx ^ history;
        readClkEn = 1'b1;
        step();
        checkBit("predValid", predValid, 1'b1);
        checkBit("pred", pred, exp);
        readClkEn = 1'b0;
    endtask

    task automatic resetDut();
        int lowCycles;
        lowCycles = 0;
        rst = 1'b1;
        step();
        step();
        rst = 1'b0;
        while (!ready0) begin
            lowCycles++;
            if (lowCycles > 4 * InitCycles) reportFailure("ready never rose after reset");
            step();
        end
        if (lowCycles != InitCycles) begin
            reportFailure($sformatf("CHECK FAILED at %0t: ready low cycles got %0d expected %0d",
                $time, lowCycles, InitCycles));
        end
    endtask

    initial begin
        ghtWriteT idle;
        ghtIndexT a;
        logic [31:0] r;
        idle = '0;
        rst = 1'b1;
        readClkEn = 1'b0;
        ipBits = '0;
        history = '0;
        write0 = '0;
        write1 = '0;

        // sweep, then random lookups all read 0
        resetDut();
        for (int i = 0; i < 64; i++) begin
            r = nextRand();
            lookupIndex(r[15:0], 1'b0);
        end

        // port 0 write, then the held index with readClkEn low
        a = 16'h5a3c;
        issueWrites(mkWrite(1'b1, a, 1'b1), idle);
        lookupIndex(a, 1'b1);
        ipBits = ~a;
        step();
        checkBit("predValid", predValid, 1'b0);
        checkBit("pred", pred, 1'b1);
        issueWrites(mkWrite(1'b1, a, 1'b0), idle);
        checkBit("pred", pred, 1'b0);

        // different banks land at one edge
        a = 16'h1234;
        issueWrites(mkWrite(1'b1, a, 1'b1), mkWrite(1'b1, a ^ 16'h0001, 1'b1));
        checkReady("ready0", ready0, 1'b1);
        lookupIndex(a, 1'b1);
        lookupIndex(a ^ 16'h0001, 1'b1);

        // same bank, one stall cycle
        a = 16'h7788;
        issueWrites(mkWrite(1'b1, a, 1'b1), mkWrite(1'b1, a ^ 16'h0100, 1'b1));
        checkReady("ready0", ready0, 1'b0);
        checkReady("ready1", ready1, 1'b0);
        step();
        checkReady("ready0", ready0, 1'b1);
        lookupIndex(a, 1'b1);
        lookupIndex(a ^ 16'h0100, 1'b1);
        a = 16'h4c21;
        issueWrites(mkWrite(1'b1, a, 1'b0), mkWrite(1'b1, a, 1'b1));
        step();
        lookupIndex(a, 1'b1);

        // random mix, valid held until accepted
        for (int i = 0; i < RandomCycles; i++) begin
            r = nextRand();
            if (!write0.valid && r[0]) write0 = mkWrite(1'b1, r[31:16] & SmallMask, r[1]);
            r = nextRand();
            if (!write1.valid && r[0]) write1 = mkWrite(1'b1, r[31:16] & SmallMask, r[1]);
            r = nextRand();
            readClkEn = r[0] | r[1];
            ipBits = r[31:16] & SmallMask;
            history = r[15:0] & SmallMask;
            step();
            if (modelAcc0) write0.valid = 1'b0;
            if (modelAcc1) write1.valid = 1'b0;
        end
        readClkEn = 1'b0;
        issueWrites(write0, write1);

        // reset mid-run wipes earlier writes
        issueWrites(mkWrite(1'b1, 16'h0101, 1'b1), mkWrite(1'b1, 16'h0202, 1'b1));
        lookupIndex(16'h0101, 1'b1);
        resetDut();
        for (int i = 0; i < 16; i++) begin
            a = ghtIndexT'(((i >> 2) << 8) | (i & 3));
            lookupIndex(a, 1'b0);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: ghtUpdateCtrl.sv
////////////////////
// ght update controller
// clear sweep after reset, routes two update ports to banks,
// one-entry save buffer for same-bank collisions
////////////////////

`timescale 1ns/1ps

module ghtUpdateCtrl (
    input  logic              clk,
    input  logic              rst,
    input  ghtPkg::ghtWriteT  write0,
    input  ghtPkg::ghtWriteT  write1,
    output logic              ready0,
    output logic              ready1,
    output ghtPkg::bankWriteT [ghtPkg::GhtBanks-1:0] bankCmd
);
    import ghtPkg::*;

    ctrlStateT state;
    rowT rowCnt;

    logic ready;
    logic acc0;
    logic acc1;
    logic collide;
    logic direct1;
    bankIdT bank0;
    bankIdT bank1;
    bankIdT savedBank;

    // save buffer
    logic savedValid;
    ghtIndexT savedAddr;
    logic savedVal;

    logic [GhtBanks-1:0] hitSaved;
    logic [GhtBanks-1:0] hit0;
    logic [GhtBanks-1:0] hit1;

    assign ready = (state == CtrlRun) && !savedValid;
    assign ready0 = ready;
    assign ready1 = ready;

    assign bank0 = bankOf(write0.addr);
    assign bank1 = bankOf(write1.addr);
    assign savedBank = bankOf(savedAddr);

    assign acc0 = ready && write0.valid;
    assign acc1 = ready && write1.valid;
    // port 1 loses to port 0 on the same bank
    assign collide = acc0 && acc1 && (bank0 == bank1);
    assign direct1 = acc1 && !collide;

    always_comb begin
        for (int k = 0; k < GhtBanks; k++) begin
            hitSaved[k] = savedValid && (savedBank == bankIdT'(k));
            hit0[k] = acc0 && (bank0 == bankIdT'(k));
            hit1[k] = direct1 && (bank1 == bankIdT'(k));
        end
    end

    always_comb begin
        for (int k = 0; k < GhtBanks; k++) begin
            bankCmd[k] = '0;
            if (state == CtrlInit) begin
                bankCmd[k].clear = 1'b1;
                bankCmd[k].row = rowCnt;
            end else if (hitSaved[k]) begin
                bankCmd[k].en = 1'b1;
                bankCmd[k].row = rowOf(savedAddr);
                bankCmd[k].col = colOf(savedAddr);
                bankCmd[k].val = savedVal;
            end else if (hit0[k]) begin
                bankCmd[k].en = 1'b1;
                bankCmd[k].row = rowOf(write0.addr);
                bankCmd[k].col = colOf(write0.addr);
                bankCmd[k].val = write0.val;
            end else if (hit1[k]) begin
                bankCmd[k].en = 1'b1;
                bankCmd[k].row = rowOf(write1.addr);
                bankCmd[k].col = colOf(write1.addr);
                bankCmd[k].val = write1.val;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CtrlInit;
            rowCnt <= '0;
            savedValid <= 1'b0;
        end else begin
            if (state == CtrlInit) begin
                rowCnt <= rowCnt + rowT'(1);
                if (rowCnt == rowT'(InitCycles - 1)) begin
                    state <= CtrlRun;
                end
            end
            // buffer drains the cycle after it fills
            savedValid <= collide;
        end
    end

    always_ff @(posedge clk) begin
        if (collide) begin
            savedAddr <= write1.addr;
            savedVal <= write1.val;
        end
    end

    oneSourcePerBank: assert property (
        @(posedge clk) disable iff (rst)
        ((hitSaved & hit0) | (hitSaved & hit1) | (hit0 & hit1)) == '0
    ) else $error("two update sources on one bank");

    savedStallsPorts: assert property (
        @(posedge clk) disable iff (rst)
        collide |=> (savedValid && !ready0 && !ready1) ##1 !savedValid
    ) else $error("save buffer did not stall and drain");

endmodule

// File: run.sh
#!/bin/sh
# build and run the ght testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module ghtTb -o ghtSim \
    || { echo "build failed"; exit 1; }
./obj_dir/ghtSim > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation did not finish"; exit 1; }
exit 0
